//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bwt_search
FLIST     ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^No errors$$"

clean:
	rm -rf $(BUILD_DIR)

//--- batch_pkg.sv
// ----------------------------------------
// batch side: load lines, reads, results
// ----------------------------------------
package batch_pkg;

	localparam int CL             = 512; // load and output line width
	localparam int READ_NUM_WIDTH = 8;
	localparam int MAX_READ       = 256;
	localparam int MAX_READ_LEN   = 101;
	localparam int LEN_W          = 7;   // read length, match_len, min_intv
	localparam int READ_BASES_W   = MAX_READ_LEN * fmi_pkg::BASE_W;

	// load line field positions
	localparam int HDR_N_LSB  = 128; // n after the four C values
	localparam int RD_LEN_LSB = 256;
	localparam int RD_MIN_LSB = 264;

	// result buffer geometry
	localparam int RES_DEPTH = 4;
	localparam int RES_PTR_W = 2;

	// one stored read, base 0 in the lowest bits
	typedef struct packed {
		logic [READ_BASES_W-1:0] bases;
		logic [LEN_W-1:0]        len;
		logic [LEN_W-1:0]        min_intv;
	} read_t;

	typedef struct packed {
		logic [READ_NUM_WIDTH-1:0] read_num;
		logic [LEN_W-1:0]          match_len;
		fmi_pkg::pos_t             k;
		fmi_pkg::pos_t             l;
	} result_t;

endpackage

//--- bwt_search_top.sv
`timescale 1ns/1ns

module bwt_search_top
	import batch_pkg::*;
	import fmi_pkg::*;
(
	input  logic                    clk_32ui_i,
	input  logic                    rst_n_i,
	input  logic                    stall_i,

	// read loading
	input  logic                    load_valid_i,
	input  logic [CL-1:0]           load_data_i,
	input  logic [READ_NUM_WIDTH:0] batch_size_i,
	output logic                    load_done_o,

	// occurrence memory
	output logic                    dram_valid_o,
	output pos_t                    addr_k_o,
	output pos_t                    addr_l_o,
	input  logic                    dram_get_i,
	input  occ_vec_t                occ_k_i,
	input  occ_vec_t                occ_l_i,

	// results
	output logic                    output_request_o,
	input  logic                    output_permit_i,
	output logic [CL-1:0]           output_data_o,
	output logic                    output_valid_o,
	output logic                    output_finish_o
);

	pos_t [NUM_BASES-1:0] c_w; // C values from the header line
	pos_t                 n_w;

	read_fetch_if read_fetch_if_i ();
	result_if     result_if_i ();

	// ----------------------------------------
	// read store
	// ----------------------------------------
	read_ram read_ram_i (
		.clk_32ui_i   (clk_32ui_i),
		.rst_n_i      (rst_n_i),
		.stall_i      (stall_i),
		.load_valid_i (load_valid_i),
		.load_data_i  (load_data_i),
		.batch_size_i (batch_size_i),
		.load_done_o  (load_done_o),
		.c_o          (c_w),
		.n_o          (n_w),
		.fetch        (read_fetch_if_i.store)
	);

	// backward search
	fm_extend fm_extend_i (
		.clk_32ui_i   (clk_32ui_i),
		.rst_n_i      (rst_n_i),
		.stall_i      (stall_i),
		.load_done_i  (load_done_o),
		.c_i          (c_w),
		.n_i          (n_w),
		.dram_valid_o (dram_valid_o),
		.addr_k_o     (addr_k_o),
		.addr_l_o     (addr_l_o),
		.dram_get_i   (dram_get_i),
		.occ_k_i      (occ_k_i),
		.occ_l_i      (occ_l_i),
		.fetch        (read_fetch_if_i.extender),
		.res          (result_if_i.extender)
	);

	result_out result_out_i (
		.clk_32ui_i       (clk_32ui_i),
		.rst_n_i          (rst_n_i),
		.stall_i          (stall_i),
		.res              (result_if_i.sink),
		.batch_size_i     (read_fetch_if_i.batch_size), // value latched at load
		.output_request_o (output_request_o),
		.output_permit_i  (output_permit_i),
		.output_data_o    (output_data_o),
		.output_valid_o   (output_valid_o),
		.output_finish_o  (output_finish_o)
	);

endmodule

//--- filelist.f
fmi_pkg.sv
batch_pkg.sv
read_fetch_if.sv
result_if.sv
read_ram.sv
fm_extend.sv
result_out.sv
bwt_search_top.sv
tb_bwt_search.sv

//--- fm_extend.sv
`timescale 1ns/1ns

module fm_extend
	import fmi_pkg::*;
	import batch_pkg::*;
(
	input  logic                 clk_32ui_i,
	input  logic                 rst_n_i,
	input  logic                 stall_i,
	input  logic                 load_done_i,
	input  pos_t [NUM_BASES-1:0] c_i,
	input  pos_t                 n_i,
	output logic                 dram_valid_o,
	output pos_t                 addr_k_o,
	output pos_t                 addr_l_o,
	input  logic                 dram_get_i,
	input  occ_vec_t             occ_k_i,
	input  occ_vec_t             occ_l_i,
	read_fetch_if.extender       fetch,
	result_if.extender           res
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_REQUEST,
		S_WAIT,
		S_REPORT
	} state_t;

	state_t                    state_q;
	logic [READ_NUM_WIDTH:0]   read_cnt_q;  // reads finished
	logic                      dram_valid_q;
	logic [LEN_W-1:0]          pos_q;       // base being extended
	logic [LEN_W-1:0]          match_q;     // accepted bases
	read_t                     cur_read_q;
	logic [READ_NUM_WIDTH-1:0] cur_num_q;
	pos_t                      k_q;
	pos_t                      l_q;

	logic  start;
	base_t base;
	pos_t  new_k;
	pos_t  new_l;
	logic  reject;

	assign start = (state_q == S_IDLE) && load_done_i && !stall_i &&
	               (read_cnt_q != fetch.batch_size);

	// ----------------------------------------
	// next interval from returned counts
	// ----------------------------------------
	assign base   = cur_read_q.bases[BASE_W*pos_q +: BASE_W];
	assign new_k  = c_i[base] + occ_k_i[base];
	assign new_l  = c_i[base] + occ_l_i[base];
	assign reject = (new_l - new_k) < pos_t'(cur_read_q.min_intv);

	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q      <= S_IDLE;
			read_cnt_q   <= '0;
			dram_valid_q <= 1'b0;
			pos_q        <= '0;
			match_q      <= '0;
		end else if (!stall_i) begin
			case (state_q)
				S_IDLE: begin
					if (start)
						state_q <= S_FETCH;
				end
				S_FETCH: begin
					if (fetch.new_read_valid) begin
						match_q <= '0;
						pos_q   <= fetch.read.len - 1'b1; // last base first
						if (fetch.read.len == '0)
							state_q <= S_REPORT;
						else
							state_q <= S_REQUEST;
					end
				end
				S_REQUEST: begin
					dram_valid_q <= 1'b1; // k=0, l=n already set
					state_q      <= S_WAIT;
				end
				S_WAIT: begin
					if (dram_get_i) begin
						if (!reject)
							match_q <= match_q + 1'b1;
						if (reject || pos_q == '0) begin
							dram_valid_q <= 1'b0;
							state_q      <= S_REPORT;
						end else begin
							pos_q <= pos_q - 1'b1; // stays valid, new bounds next cycle
						end
					end
				end
				S_REPORT: begin
					// hold result until the buffer has room
					if (res.space) begin
						read_cnt_q <= read_cnt_q + 1'b1;
						state_q    <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (!stall_i) begin
			if (state_q == S_FETCH && fetch.new_read_valid) begin
				cur_read_q <= fetch.read;
				cur_num_q  <= fetch.read_num;
				k_q        <= '0;
				l_q        <= n_i;
			end else if (state_q == S_WAIT && dram_get_i && !reject) begin
				k_q <= new_k;
				l_q <= new_l;
			end
		end
	end

	assign fetch.new_read = start;
	assign dram_valid_o   = dram_valid_q;
	assign addr_k_o       = k_q; // request carries current bounds
	assign addr_l_o       = l_q;

	assign res.ret_valid = (state_q == S_REPORT) && res.space && !stall_i;
	assign res.ret       = '{read_num: cur_num_q, match_len: match_q, k: k_q, l: l_q};

endmodule

//--- fmi_pkg.sv
// ----------------------------------------
// FM-index side: bases, positions, counts
// ----------------------------------------
package fmi_pkg;

	localparam int BASE_W    = 2;  // bits per base code
	localparam int NUM_BASES = 4;  // A C G T
	localparam int POS_W     = 32; // BWT position width

	// base code: A=0, C=1, G=2, T=3
	typedef logic [BASE_W-1:0] base_t;

	// interval bound or BWT position
	typedef logic [POS_W-1:0] pos_t;

	// occurrence counts of all four bases at one bound,
	// entry [c] is the count for base c
	typedef pos_t [NUM_BASES-1:0] occ_vec_t;

endpackage

//--- read_fetch_if.sv
`timescale 1ns/1ns

// read store -> extender
interface read_fetch_if
	import batch_pkg::*;
();

	logic                      new_read;       // strobe from extender
	logic                      new_read_valid; // two cycles after new_read
	logic [READ_NUM_WIDTH-1:0] read_num;
	read_t                     read;
	logic [READ_NUM_WIDTH:0]   batch_size;     // reads in this batch

	modport store (input new_read, output new_read_valid, read_num, read, batch_size);

	modport extender (output new_read, input new_read_valid, read_num, read, batch_size);

endinterface

//--- read_ram.sv
`timescale 1ns/1ns

module read_ram
	import fmi_pkg::*;
	import batch_pkg::*;
(
	input  logic                    clk_32ui_i,
	input  logic                    rst_n_i,
	input  logic                    stall_i,
	input  logic                    load_valid_i,
	input  logic [CL-1:0]           load_data_i,
	input  logic [READ_NUM_WIDTH:0] batch_size_i,
	output logic                    load_done_o,
	output pos_t [NUM_BASES-1:0]    c_o,
	output pos_t                    n_o,
	read_fetch_if.store             fetch
);

	read_t read_mem [MAX_READ];

	logic [READ_NUM_WIDTH:0]   line_cnt_q;   // line 0 is the header
	logic [READ_NUM_WIDTH:0]   batch_size_q;
	logic                      load_done_q;
	logic                      load_we;
	logic [READ_NUM_WIDTH-1:0] wr_addr;
	read_t                     line_read;

	logic [READ_NUM_WIDTH-1:0] next_num_q;   // next read handed out
	logic                      fetch_pend_q;
	logic [READ_NUM_WIDTH-1:0] fetch_addr_q;
	logic                      fetch_valid_q;
	read_t                     read_q;
	logic [READ_NUM_WIDTH-1:0] read_num_q;

	// ----------------------------------------
	// loading
	// ----------------------------------------
	assign load_we = load_valid_i && !load_done_q && !stall_i;
	assign wr_addr = line_cnt_q[READ_NUM_WIDTH-1:0] - 1'b1;

	always_comb begin
		line_read.bases    = load_data_i[READ_BASES_W-1:0];
		line_read.len      = load_data_i[RD_LEN_LSB +: LEN_W];
		line_read.min_intv = load_data_i[RD_MIN_LSB +: LEN_W];
	end

	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			line_cnt_q   <= '0;
			batch_size_q <= '0;
			load_done_q  <= 1'b0;
		end else if (load_we) begin
			line_cnt_q <= line_cnt_q + 1'b1;
			if (line_cnt_q == '0)
				batch_size_q <= batch_size_i;
			else if (line_cnt_q == batch_size_q)
				load_done_q <= 1'b1; // last read line
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (load_we && line_cnt_q == '0) begin
			for (int i = 0; i < NUM_BASES; i++)
				c_o[i] <= load_data_i[POS_W*i +: POS_W];
			n_o <= load_data_i[HDR_N_LSB +: POS_W];
		end
		if (load_we && line_cnt_q != '0)
			read_mem[wr_addr] <= line_read;
	end

	// ----------------------------------------
	// fetch, two register stages
	// ----------------------------------------
	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			next_num_q    <= '0;
			fetch_pend_q  <= 1'b0;
			fetch_addr_q  <= '0;
			fetch_valid_q <= 1'b0;
		end else if (!stall_i) begin
			fetch_pend_q  <= fetch.new_read;
			fetch_valid_q <= fetch_pend_q;
			if (fetch.new_read) begin
				fetch_addr_q <= next_num_q;
				next_num_q   <= next_num_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (!stall_i && fetch_pend_q) begin
			read_q     <= read_mem[fetch_addr_q];
			read_num_q <= fetch_addr_q;
		end
	end

	assign fetch.new_read_valid = fetch_valid_q;
	assign fetch.read           = read_q;
	assign fetch.read_num       = read_num_q;
	assign fetch.batch_size     = batch_size_q;
	assign load_done_o          = load_done_q;

endmodule

//--- result_if.sv
`timescale 1ns/1ns

// extender -> output stage
interface result_if
	import batch_pkg::*;
();

	logic    ret_valid; // one cycle per finished read
	result_t ret;
	logic    space;     // buffer can take one more

	modport extender (output ret_valid, ret, input space);

	modport sink (input ret_valid, ret, output space);

endinterface

//--- result_out.sv
`timescale 1ns/1ns

module result_out
	import batch_pkg::*;
(
	input  logic                    clk_32ui_i,
	input  logic                    rst_n_i,
	input  logic                    stall_i,
	result_if.sink                  res,
	input  logic [READ_NUM_WIDTH:0] batch_size_i,
	output logic                    output_request_o,
	input  logic                    output_permit_i,
	output logic [CL-1:0]           output_data_o,
	output logic                    output_valid_o,
	output logic                    output_finish_o
);

	result_t res_buf [RES_DEPTH];

	logic [RES_PTR_W-1:0]    wr_ptr_q;
	logic [RES_PTR_W-1:0]    rd_ptr_q;
	logic [RES_PTR_W:0]      cnt_q;     // 0..RES_DEPTH
	logic [READ_NUM_WIDTH:0] sent_q;
	logic                    finish_q;
	logic                    empty;
	logic                    push;
	logic                    pop;

	assign empty = (cnt_q == '0);
	assign push  = res.ret_valid && res.space && !stall_i;
	assign pop   = output_permit_i && !empty && !stall_i;

	// ----------------------------------------
	// circular buffer
	// ----------------------------------------
	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (push)
			res_buf[wr_ptr_q] <= res.ret;
	end

	// lines sent, finish once the whole batch is out
	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sent_q   <= '0;
			finish_q <= 1'b0;
		end else if (pop) begin
			sent_q <= sent_q + 1'b1;
			if (sent_q + 1'b1 == batch_size_i)
				finish_q <= 1'b1;
		end
	end

	assign res.space        = (cnt_q != RES_DEPTH);
	assign output_request_o = !empty;
	assign output_valid_o   = pop;
	assign output_data_o    = {{(CL-$bits(result_t)){1'b0}}, res_buf[rd_ptr_q]};
	assign output_finish_o  = finish_q;

endmodule

//--- search_vectors.txt
# B <bwt text>   H <C[A]> <C[C]> <C[G]> <C[T]> <n>
# R <read, base 0 first> <min_intv> <match_len> <k> <l>
#
# bwt text, 64 bases
B ACGTACGTACGTACGTACGTACGTACGTACGTACGTACGTACGTACGTACGTACGTACGTACGT
#
# header values
H 0 16 32 48 64
#
# reads with expected results
#
# stops on the fourth base, width drops to zero
R ACGT 1 3 27 28
# full match
R TCGT 1 4 54 55
# long full match
R AGCAGCA 1 7 9 10
# second base gives width 4, below 5
R GT 5 1 48 64
# first base already below min_intv
R CA 17 0 0 64
# empty interval still accepted
R ACGT 0 4 7 7
# single base, width exactly at min_intv
R G 16 1 32 48
# stops on the fifth base
R GTTTT 1 4 63 64

//--- tb_bwt_search.sv
`timescale 1ns/1ns

module tb_bwt_search
	import fmi_pkg::*;
	import batch_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 10;
	localparam int SEED         = 63;
	localparam int MAX_VEC      = 16;
	localparam int READ_TIMEOUT = 500; // cycles allowed per read

	logic                    clk;
	logic                    rst_n_i;
	logic                    stall_i;
	logic                    load_valid_i;
	logic [CL-1:0]           load_data_i;
	logic [READ_NUM_WIDTH:0] batch_size_i;
	logic                    load_done_o;
	logic                    dram_valid_o;
	pos_t                    addr_k_o;
	pos_t                    addr_l_o;
	logic                    dram_get_i      = 1'b0;
	occ_vec_t                occ_k_i         = '0;
	occ_vec_t                occ_l_i         = '0;
	logic                    output_request_o;
	logic                    output_permit_i = 1'b0;
	logic [CL-1:0]           output_data_o;
	logic                    output_valid_o;
	logic                    output_finish_o;

	// vectors from file
	string       bwt_text;
	logic [31:0] c_val [NUM_BASES];
	logic [31:0] n_val;
	string       rd_str [MAX_VEC];
	int          rd_min [MAX_VEC];
	int          exp_match [MAX_VEC];
	int          exp_k [MAX_VEC];
	int          exp_l [MAX_VEC];
	int          nreads = 0;
	bit          vectors_ready = 0;

	logic [31:0] rng_state = SEED;
	int err_cnt = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int out_cnt = 0;
	int req_cnt = 0;
	int first_req_cnt = 0;
	bit finish_seen = 0;

	bwt_search_top bwt_search_top_i (
		.clk_32ui_i       (clk),
		.rst_n_i          (rst_n_i),
		.stall_i          (stall_i),
		.load_valid_i     (load_valid_i),
		.load_data_i      (load_data_i),
		.batch_size_i     (batch_size_i),
		.load_done_o      (load_done_o),
		.dram_valid_o     (dram_valid_o),
		.addr_k_o         (addr_k_o),
		.addr_l_o         (addr_l_o),
		.dram_get_i       (dram_get_i),
		.occ_k_i          (occ_k_i),
		.occ_l_i          (occ_l_i),
		.output_request_o (output_request_o),
		.output_permit_i  (output_permit_i),
		.output_data_o    (output_data_o),
		.output_valid_o   (output_valid_o),
		.output_finish_o  (output_finish_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [1:0] base_code(input byte ch);
		case (ch)
			"A": return 2'd0;
			"C": return 2'd1;
			"G": return 2'd2;
			default: return 2'd3; // T
		endcase
	endfunction

	// count of base b in the BWT below position pos
	function automatic logic [31:0] count_occ(input logic [1:0] b, input logic [31:0] pos);
		logic [31:0] cnt;
		cnt = '0;
		for (int i = 0; i < bwt_text.len(); i++)
			if (i < pos && base_code(bwt_text.getc(i)) == b)
				cnt = cnt + 1;
		return cnt;
	endfunction

	function automatic logic [CL-1:0] header_line();
		logic [CL-1:0] line;
		line = '0;
		for (int i = 0; i < NUM_BASES; i++)
			line[32*i +: 32] = c_val[i];
		line[128 +: 32] = n_val;
		return line;
	endfunction

	function automatic logic [CL-1:0] read_line(input int idx);
		string         s;
		logic [CL-1:0] line;
		s    = rd_str[idx];
		line = '0;
		for (int i = 0; i < s.len(); i++)
			line[2*i +: 2] = base_code(s.getc(i)); // base 0 lowest
		line[256 +: 7] = 7'(s.len());
		line[264 +: 7] = 7'(rd_min[idx]);
		return line;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %0d, actual %0d", what, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic flag_error(input string msg);
		$display("Error: %s", msg);
		err_cnt++;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed", name);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$finish;
	endtask

	task automatic check_line(input int idx);
		int    errs_before;
		string name;
		errs_before = err_cnt;
		name        = $sformatf("read %0d", idx);
		check_value({name, " read_num"}, idx, 32'(output_data_o[78:71]));
		check_value({name, " match_len"}, exp_match[idx], 32'(output_data_o[70:64]));
		check_value({name, " k"}, exp_k[idx], output_data_o[63:32]);
		check_value({name, " l"}, exp_l[idx], output_data_o[31:0]);
		finish_test(name, errs_before);
	endtask

	task automatic read_vectors();
		int    fd;
		int    code;
		string line;
		fd = $fopen("search_vectors.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open search_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (code == 0)
					break;
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				case (line.getc(0))
					"B": code = $sscanf(line, "B %s", bwt_text);
					"H": code = $sscanf(line, "H %d %d %d %d %d", c_val[0], c_val[1],
					                    c_val[2], c_val[3], n_val);
					"R": if (nreads < MAX_VEC) begin
						code = $sscanf(line, "R %s %d %d %d %d", rd_str[nreads],
						               rd_min[nreads], exp_match[nreads], exp_k[nreads],
						               exp_l[nreads]);
						nreads++;
					end
					default: ;
				endcase
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------
	// memory model and random permit
	// ----------------------------------------
	bit pending = 0;
	bit valid_prev = 0;
	int delay_left = 0;

	always @(posedge clk) begin
		if (rst_n_i) begin
			rng_state = xorshift32(rng_state);
			output_permit_i <= rng_state[7];
			if (dram_get_i) begin
				if (!stall_i) begin // taken at this edge
					dram_get_i <= 1'b0;
					pending = 0;
				end
			end else if (pending) begin
				if (!stall_i) begin
					if (delay_left == 0) begin
						for (int b = 0; b < NUM_BASES; b++) begin
							occ_k_i[b] <= count_occ(2'(b), addr_k_o);
							occ_l_i[b] <= count_occ(2'(b), addr_l_o);
						end
						dram_get_i <= 1'b1;
					end else begin
						delay_left--;
					end
				end
			end else if (dram_valid_o) begin
				pending = 1;
				rng_state = xorshift32(rng_state);
				delay_left = int'(rng_state % 6);
				req_cnt++;
				if (addr_k_o > addr_l_o)
					flag_error("request with addr_k_o above addr_l_o");
				if (!valid_prev) begin // first base of a read
					first_req_cnt++;
					check_value("first request k", 0, addr_k_o);
					check_value("first request l", n_val, addr_l_o);
				end
			end
			valid_prev = dram_valid_o;
		end
	end

	// output lines sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n_i && output_valid_o) begin
			if (!output_permit_i)
				flag_error("output_valid_o pulsed while output_permit_i was low");
			if (stall_i)
				flag_error("output_valid_o pulsed during stall");
			if (out_cnt >= nreads)
				flag_error("more output lines than reads in the batch");
			else
				check_line(out_cnt);
			out_cnt++;
		end
		if (rst_n_i && output_request_o && output_permit_i && !stall_i && !output_valid_o)
			flag_error("a waiting line was not sent although output_permit_i was high");
		if (output_finish_o && !finish_seen) begin
			finish_seen = 1;
			check_value("lines at finish", nreads, out_cnt);
		end
	end

	initial begin
		wait (vectors_ready);
		if (nreads == 0) begin
			abort_run("no reads found in search_vectors.txt");
		end else begin
			#(CLK_PERIOD * (RESET_CYCLES + nreads + 40 + READ_TIMEOUT * nreads));
			abort_run("Timeout: the batch did not finish in time");
		end
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int errs_before;
		int snap_req;
		int snap_out;
		rst_n_i      = 1'b0;
		stall_i      = 1'b0;
		load_valid_i = 1'b0;
		load_data_i  = '0;
		batch_size_i = '0;
		read_vectors();
		vectors_ready = 1;

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;
		@(negedge clk);
		errs_before = err_cnt;
		check_value("reset load_done_o", 0, 32'(load_done_o));
		check_value("reset dram_valid_o", 0, 32'(dram_valid_o));
		check_value("reset output_request_o", 0, 32'(output_request_o));
		check_value("reset output_valid_o", 0, 32'(output_valid_o));
		check_value("reset output_finish_o", 0, 32'(output_finish_o));
		finish_test("reset", errs_before);

		// header line first and one line per read after it
		errs_before = err_cnt;
		for (int i = 0; i <= nreads; i++) begin
			@(posedge clk);
			load_valid_i <= 1'b1;
			load_data_i  <= (i == 0) ? header_line() : read_line(i - 1);
			batch_size_i <= 9'(nreads);
			@(negedge clk);
			check_value("load_done_o before last line", 0, 32'(load_done_o));
		end
		@(posedge clk);
		load_valid_i <= 1'b0;
		load_data_i  <= '0;
		@(negedge clk);
		check_value("load_done_o after last line", 1, 32'(load_done_o));
		finish_test("load", errs_before);

		// freeze mid-run
		wait (out_cnt >= 2);
		errs_before = err_cnt;
		@(posedge clk);
		stall_i <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		snap_req = req_cnt;
		snap_out = out_cnt;
		repeat (17) @(posedge clk);
		@(negedge clk);
		check_value("requests during stall", snap_req, req_cnt);
		check_value("lines during stall", snap_out, out_cnt);
		@(posedge clk);
		stall_i <= 1'b0;
		finish_test("stall", errs_before);

		wait (output_finish_o);
		repeat (4) @(posedge clk);
		@(negedge clk);
		errs_before = err_cnt;
		check_value("lines sent", nreads, out_cnt);
		check_value("reads started", nreads, first_req_cnt);
		check_value("output_finish_o held", 1, 32'(output_finish_o));
		finish_test("finish", errs_before);

		$display("tests run %0d, tests failed %0d, checks failed %0d",
		         tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
